// ==== flist.f ====
logic/fuse_svc_pkg.sv
logic/fuse_mem_if.sv
logic/fuse_array.sv
logic/fuse_arbiter.sv
logic/fault_injector.sv
logic/partition_scanner.sv
logic/fuse_svc_top.sv
testbench/tb_fuse_svc.sv

// ==== Bender.yml ====
package:
  name: fuse_svc

sources:
  # Package and interface come first, then the blocks and the top level.
  - files:
      - logic/fuse_svc_pkg.sv
      - logic/fuse_mem_if.sv
      - logic/fuse_array.sv
      - logic/fuse_arbiter.sv
      - logic/fault_injector.sv
      - logic/partition_scanner.sv
      - logic/fuse_svc_top.sv

  - target: simulation
    files:
      - testbench/tb_fuse_svc.sv

// ==== testbench/tb_fuse_svc.sv ====
// ----------------------------------------------------------
// Fuse service testbench.
// Loads a random image with locked partitions, issues service
// commands and checks flags and the sub-block reset.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_fuse_svc;

  localparam int part_cnt     = 4;
  localparam int part_stride  = 8;
  localparam int digest_pos   = 4;
  localparam int sub_rst_len  = 10;
  localparam int pass_timeout = 200;

  localparam logic [7:0] cmd_corr    = 8'h01;
  localparam logic [7:0] cmd_uncorr  = 8'h02;
  localparam logic [7:0] cmd_release = 8'h03;
  localparam logic [7:0] cmd_sub_rst = 8'h10;
  localparam logic [7:0] cmd_unknown = 8'h5a;

  logic        clk;
  logic        cptra_rst_b;
  logic        cmd_valid_i;
  logic [7:0]  cmd_i;
  logic        host_we_i;
  logic [4:0]  host_addr_i;
  logic [15:0] host_wdata_i;
  logic        sub_rst_o;
  logic [3:0]  err_corr_o;
  logic [3:0]  err_fatal_o;
  logic        scan_done_o;

  // Reference model of the fuse image and the sticky flags.
  logic [15:0] img [part_cnt * part_stride];
  logic [15:0] saved [part_cnt];
  logic        fault_active;
  logic [3:0]  exp_corr;
  logic [3:0]  exp_fatal;
  logic        check_en;
  logic [31:0] rng;
  int          rst_left;

  fuse_svc_top i_dut (
    .clk          (clk),
    .cptra_rst_b  (cptra_rst_b),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .sub_rst_o    (sub_rst_o),
    .err_corr_o   (err_corr_o),
    .err_fatal_o  (err_fatal_o),
    .scan_done_o  (scan_done_o)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  // The expected sub-block reset window counts down from the accepted strobe.
  always @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rst_left <= 0;
    end else if (cmd_valid_i && (cmd_i == cmd_sub_rst) && (rst_left == 0)) begin
      rst_left <= sub_rst_len;
    end else if (rst_left != 0) begin
      rst_left <= rst_left - 1;
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_idle_after_reset : assert property (
    @(posedge clk) $rose(cptra_rst_b) |->
      !sub_rst_o && !scan_done_o && (err_corr_o == '0) && (err_fatal_o == '0)
  ) else abort_run($sformatf("Error at %0t ns: outputs not idle after reset", $time));

  a_flags_match : assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    check_en |-> (err_corr_o == exp_corr) && (err_fatal_o == exp_fatal)
  ) else abort_run($sformatf("Error at %0t ns: corr=%b fatal=%b, expected corr=%b fatal=%b",
                             $time, $sampled(err_corr_o), $sampled(err_fatal_o),
                             exp_corr, exp_fatal));

  a_sub_rst_window : assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    sub_rst_o == (rst_left != 0)
  ) else abort_run($sformatf("Error at %0t ns: sub_rst_o=%b, expected %b",
                             $time, $sampled(sub_rst_o), $sampled(rst_left) != 0));

  a_quiet_in_sub_rst : assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    sub_rst_o |-> (err_corr_o == '0) && (err_fatal_o == '0) && !scan_done_o
  ) else abort_run($sformatf("Error at %0t ns: scanner active during sub-block reset", $time));

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Returns the fatal flags in the upper nibble and the correctable ones below.
  function automatic logic [7:0] judge_image();
    logic [3:0]  corr;
    logic [3:0]  fatal;
    logic [15:0] fold;
    logic [15:0] digest;
    int          diff;
    corr  = '0;
    fatal = '0;
    for (int p = 0; p < part_cnt; p++) begin
      fold   = '0;
      digest = img[p * part_stride + digest_pos];
      for (int w = 0; w < 4; w++) begin
        fold = fold ^ img[p * part_stride + w];
      end
      diff = $countones(fold ^ digest);
      if ((digest != '0) && (diff == 1)) begin
        corr[p] = 1'b1;
      end else if ((digest != '0) && (diff > 1)) begin
        fatal[p] = 1'b1;
      end
    end
    return {fatal, corr};
  endfunction

  task automatic apply_model(input logic [7:0] code);
    int base;
    if (((code == cmd_corr) || (code == cmd_uncorr)) && !fault_active) begin
      fault_active = 1'b1;
      for (int p = 0; p < part_cnt; p++) begin
        base = p * part_stride;
        if (img[base + digest_pos] != '0) begin
          saved[p]  = img[base];
          img[base] = (code == cmd_uncorr) ? ~img[base] : (img[base] ^ 16'h0001);
        end
      end
    end else if ((code == cmd_release) && fault_active) begin
      fault_active = 1'b0;
      for (int p = 0; p < part_cnt; p++) begin
        if (img[p * part_stride + digest_pos] != '0) begin
          img[p * part_stride] = saved[p];
        end
      end
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  task automatic host_write(input int addr, input logic [15:0] data);
    @(negedge clk);
    host_we_i    = 1'b1;
    host_addr_i  = addr[4:0];
    host_wdata_i = data;
  endtask

  task automatic load_image();
    int          base;
    logic [15:0] fold;
    for (int p = 0; p < part_cnt; p++) begin
      base = p * part_stride;
      fold = '0;
      for (int w = 0; w < 4; w++) begin
        rng           = xorshift32(rng);
        img[base + w] = rng[15:0];
        fold          = fold ^ rng[15:0];
      end
      // Partitions 0 and 2 are locked and need a non-zero digest.
      if ((p == 0) || (p == 2)) begin
        if (fold == '0) begin
          img[base + 3] = img[base + 3] ^ 16'h0001;
          fold          = 16'h0001;
        end
        img[base + digest_pos] = fold;
      end else begin
        img[base + digest_pos] = '0;
      end
    end
    // Data goes in before any digest, so no pass judges a half-loaded partition.
    for (int p = 0; p < part_cnt; p++) begin
      for (int w = 0; w < 4; w++) begin
        host_write(p * part_stride + w, img[p * part_stride + w]);
      end
    end
    for (int p = 0; p < part_cnt; p++) begin
      host_write(p * part_stride + digest_pos, img[p * part_stride + digest_pos]);
    end
    @(negedge clk);
    host_we_i = 1'b0;
  endtask

  task automatic wait_passes(input int count);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while ((seen < count) && (cycles < count * pass_timeout)) begin
      @(negedge clk);
      cycles++;
      if (scan_done_o) begin
        seen++;
      end
    end
    if (seen < count) begin
      abort_run("Timed out waiting for the end of a scan pass.");
    end
  endtask

  task automatic wait_sub_rst(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while ((sub_rst_o !== level) && (cycles < limit)) begin
      @(negedge clk);
      cycles++;
    end
    if (sub_rst_o !== level) begin
      abort_run("Timed out waiting for the sub-block reset to change.");
    end
  endtask

  task automatic strobe_cmd(input logic [7:0] code);
    @(negedge clk);
    cmd_valid_i = 1'b1;
    cmd_i       = code;
    @(negedge clk);
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
  endtask

  task automatic send_cmd(input logic [7:0] code);
    logic [7:0] judged;
    logic [3:0] next_corr;
    logic [3:0] next_fatal;
    apply_model(code);
    judged     = judge_image();
    next_corr  = (code == cmd_sub_rst) ? judged[3:0] : (exp_corr | judged[3:0]);
    next_fatal = (code == cmd_sub_rst) ? judged[7:4] : (exp_fatal | judged[7:4]);
    // Flags may move until the scanner has seen the new image.
    if ((code == cmd_sub_rst) || (next_corr != exp_corr) || (next_fatal != exp_fatal)) begin
      check_en = 1'b0;
    end
    strobe_cmd(code);
    if (code == cmd_sub_rst) begin
      wait_sub_rst(1'b1, 4);
      wait_sub_rst(1'b0, sub_rst_len + 4);
    end
    // The pass under way may overlap the fault writes. Two whole passes follow it.
    wait_passes(3);
    exp_corr  = next_corr;
    exp_fatal = next_fatal;
    check_en  = 1'b1;
  endtask

  initial begin
    clk          = 1'b0;
    cptra_rst_b  = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    fault_active = 1'b0;
    exp_corr     = '0;
    exp_fatal    = '0;
    check_en     = 1'b0;
    rng          = 32'd71;
    repeat (10) @(posedge clk);
    @(negedge clk);
    cptra_rst_b = 1'b1;

    load_image();
    wait_passes(3);
    {exp_fatal, exp_corr} = judge_image();
    check_en = 1'b1;

    send_cmd(cmd_corr);
    // A second fault while one is active, and a stray code, are dropped.
    send_cmd(cmd_uncorr);
    send_cmd(cmd_unknown);
    send_cmd(cmd_sub_rst);
    send_cmd(cmd_release);
    send_cmd(cmd_sub_rst);
    send_cmd(cmd_uncorr);
    send_cmd(cmd_corr);
    send_cmd(cmd_unknown);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/fuse_svc_top.sv ====
// ----------------------------------------------------------
// Fuse service top level.
// Host write port, fault injector and partition scanner share
// the fuse array through the fixed-priority arbiter.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fuse_svc_top (
  input  logic                     clk,
  input  logic                     cptra_rst_b,
  input  logic                     cmd_valid_i,
  input  fuse_svc_pkg::svc_cmd_t   cmd_i,
  input  logic                     host_we_i,
  input  fuse_svc_pkg::fuse_addr_t host_addr_i,
  input  fuse_svc_pkg::fuse_word_t host_wdata_i,
  output logic                     sub_rst_o,
  output fuse_svc_pkg::part_vec_t  err_corr_o,
  output fuse_svc_pkg::part_vec_t  err_fatal_o,
  output logic                     scan_done_o
);

  fuse_mem_if host_bus ();
  fuse_mem_if inj_bus ();
  fuse_mem_if scan_bus ();
  fuse_mem_if mem_bus ();

  // The host has top priority, so its write strobe is never stalled.
  assign host_bus.req   = host_we_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.wdata = host_wdata_i;

  fuse_arbiter i_arbiter (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .host        (host_bus.arbiter),
    .inj         (inj_bus.arbiter),
    .scan        (scan_bus.arbiter),
    .mem         (mem_bus.requester)
  );

  fuse_array i_array (
    .clk (clk),
    .mem (mem_bus.arbiter)
  );

  fault_injector i_injector (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .bus         (inj_bus.requester),
    .sub_rst_o   (sub_rst_o)
  );

  partition_scanner i_scanner (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .sub_rst_i   (sub_rst_o),
    .bus         (scan_bus.requester),
    .err_corr_o  (err_corr_o),
    .err_fatal_o (err_fatal_o),
    .scan_done_o (scan_done_o)
  );

endmodule

`default_nettype wire

// ==== logic/partition_scanner.sv ====
// ----------------------------------------------------------
// Partition scanner.
// Walks all partitions without end, folds each one's data
// words by XOR and compares the result with its digest.
// One differing bit is correctable and more are fatal.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module partition_scanner (
  input  logic                    clk,
  input  logic                    cptra_rst_b,
  input  logic                    sub_rst_i,
  fuse_mem_if.requester           bus,
  output fuse_svc_pkg::part_vec_t err_corr_o,
  output fuse_svc_pkg::part_vec_t err_fatal_o,
  output logic                    scan_done_o
);
  import fuse_svc_pkg::*;

  typedef enum logic [1:0] {
    ScanIdle,
    ScanReq,
    ScanWait
  } scan_state_e;

  scan_state_e                           state_q;
  part_idx_t                             part_q;
  word_idx_t                             word_q;
  fuse_word_t                            fold_q;
  part_vec_t                             corr_q;
  part_vec_t                             fatal_q;
  logic                                  done_q;
  logic                                  at_digest;
  logic                                  last_part;
  logic [$clog2($bits(fuse_word_t)):0]   diff_cnt;

  assign at_digest = (word_q == word_idx_t'(DigestOffset));
  assign last_part = (part_q == part_idx_t'(NumParts - 1));

  // Number of bits where the folded data and the stored digest disagree.
  assign diff_cnt = ($clog2($bits(fuse_word_t)) + 1)'($countones(fold_q ^ bus.rdata));

  assign bus.req   = (state_q == ScanReq);
  assign bus.we    = 1'b0;
  assign bus.addr  = part_base(part_q) + fuse_addr_t'(word_q);
  assign bus.wdata = '0;

  // ----------------------------------------------------------
  // Scan sequencing and error flags
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      state_q <= ScanIdle;
      part_q  <= '0;
      word_q  <= '0;
      corr_q  <= '0;
      fatal_q <= '0;
      done_q  <= 1'b0;
    end else if (sub_rst_i) begin
      state_q <= ScanIdle;
      part_q  <= '0;
      word_q  <= '0;
      corr_q  <= '0;
      fatal_q <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      unique case (state_q)
        ScanIdle: begin
          // The first request of a pass follows one cycle after any reset.
          state_q <= ScanReq;
        end
        ScanReq: begin
          if (bus.gnt) begin
            state_q <= ScanWait;
          end
        end
        ScanWait: begin
          state_q <= ScanReq;
          if (!at_digest) begin
            // After the last data word the digest comes next.
            if (word_q == word_idx_t'(PartDataWords - 1)) begin
              word_q <= word_idx_t'(DigestOffset);
            end else begin
              word_q <= word_q + 1'b1;
            end
          end else begin
            // Unlocked partitions carry a zero digest and are not judged.
            if (bus.rdata != '0) begin
              if (diff_cnt == 1) begin
                corr_q[part_q] <= 1'b1;
              end else if (diff_cnt > 1) begin
                fatal_q[part_q] <= 1'b1;
              end
            end
            word_q <= '0;
            part_q <= last_part ? '0 : part_q + 1'b1;
            done_q <= last_part;
          end
        end
        default: begin
          state_q <= ScanReq;
        end
      endcase
    end
  end

  // The fold restarts with the first data word of every partition.
  always_ff @(posedge clk) begin
    if ((state_q == ScanWait) && !at_digest) begin
      fold_q <= (word_q == '0) ? bus.rdata : (fold_q ^ bus.rdata);
    end
  end

  // Flags read as clear for the whole sub-block reset window.
  assign err_corr_o  = sub_rst_i ? '0 : corr_q;
  assign err_fatal_o = sub_rst_i ? '0 : fatal_q;
  assign scan_done_o = done_q & ~sub_rst_i;

endmodule

`default_nettype wire

// ==== logic/fault_injector.sv ====
// ----------------------------------------------------------
// Fuse fault injector.
// Decodes service commands, corrupts the first data word of
// every locked partition, restores it on release and times
// the sub-block reset.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fault_injector (
  input  logic                   clk,
  input  logic                   cptra_rst_b,
  input  logic                   cmd_valid_i,
  input  fuse_svc_pkg::svc_cmd_t cmd_i,
  fuse_mem_if.requester          bus,
  output logic                   sub_rst_o
);
  import fuse_svc_pkg::*;

  typedef enum logic [2:0] {
    InjIdle,
    InjRdDigest,
    InjWaitDigest,
    InjRdData,
    InjWaitData,
    InjWrData,
    InjRelease
  } inj_state_e;

  inj_state_e            state_q;
  part_idx_t             part_q;
  part_vec_t             locked_q;
  logic                  fault_active_q;
  logic                  uncorr_q;
  fuse_word_t            fault_word_q;
  fuse_word_t            saved_q [NumParts];
  logic                  last_part;
  logic                  inj_start;
  logic                  rel_start;
  logic                  rst_start;
  logic                  sub_rst_q;
  logic [SubRstCntW-1:0] rst_cnt_q;

  assign last_part = (part_q == part_idx_t'(NumParts - 1));

  // Commands are taken only while idle; anything else is dropped.
  assign inj_start = cmd_valid_i && (state_q == InjIdle) && !fault_active_q &&
                     ((cmd_i == CmdCorrFault) || (cmd_i == CmdUncorrFault));
  assign rel_start = cmd_valid_i && (state_q == InjIdle) && fault_active_q &&
                     (cmd_i == CmdReleaseFault);
  assign rst_start = cmd_valid_i && (state_q == InjIdle) && !sub_rst_q &&
                     (cmd_i == CmdSubReset);

  // ----------------------------------------------------------
  // Injection and release FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      state_q        <= InjIdle;
      part_q         <= '0;
      locked_q       <= '0;
      fault_active_q <= 1'b0;
      uncorr_q       <= 1'b0;
    end else begin
      unique case (state_q)
        InjIdle: begin
          if (inj_start) begin
            state_q        <= InjRdDigest;
            part_q         <= '0;
            locked_q       <= '0;
            fault_active_q <= 1'b1;
            uncorr_q       <= (cmd_i == CmdUncorrFault);
          end else if (rel_start) begin
            state_q <= InjRelease;
            part_q  <= '0;
          end
        end
        InjRdDigest: begin
          if (bus.gnt) begin
            state_q <= InjWaitDigest;
          end
        end
        InjWaitDigest: begin
          // A zero digest means the partition is not locked.
          if (bus.rdata != '0) begin
            locked_q[part_q] <= 1'b1;
            state_q          <= InjRdData;
          end else if (last_part) begin
            state_q <= InjIdle;
          end else begin
            part_q  <= part_q + 1'b1;
            state_q <= InjRdDigest;
          end
        end
        InjRdData: begin
          if (bus.gnt) begin
            state_q <= InjWaitData;
          end
        end
        InjWaitData: begin
          state_q <= InjWrData;
        end
        InjWrData: begin
          if (bus.gnt) begin
            part_q  <= part_q + 1'b1;
            state_q <= last_part ? InjIdle : InjRdDigest;
          end
        end
        InjRelease: begin
          if (bus.gnt || !locked_q[part_q]) begin
            part_q <= part_q + 1'b1;
            if (last_part) begin
              state_q        <= InjIdle;
              fault_active_q <= 1'b0;
            end
          end
        end
        default: begin
          state_q <= InjIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == InjWaitData) begin
      saved_q[part_q] <= bus.rdata;
      fault_word_q    <= uncorr_q ? ~bus.rdata : (bus.rdata ^ fuse_word_t'(1));
    end
  end

  always_comb begin
    bus.req   = 1'b0;
    bus.we    = 1'b0;
    bus.addr  = part_base(part_q);
    bus.wdata = fault_word_q;
    unique case (state_q)
      InjRdDigest: begin
        bus.req  = 1'b1;
        bus.addr = digest_addr(part_q);
      end
      InjRdData: begin
        bus.req = 1'b1;
      end
      InjWrData: begin
        bus.req = 1'b1;
        bus.we  = 1'b1;
      end
      InjRelease: begin
        bus.req   = locked_q[part_q];
        bus.we    = 1'b1;
        bus.wdata = saved_q[part_q];
      end
      default: begin
        bus.req = 1'b0;
      end
    endcase
  end

  // ----------------------------------------------------------
  // Sub-block reset timer
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      sub_rst_q <= 1'b0;
      rst_cnt_q <= '0;
    end else if (rst_start) begin
      sub_rst_q <= 1'b1;
      rst_cnt_q <= '0;
    end else if (sub_rst_q) begin
      rst_cnt_q <= rst_cnt_q + 1'b1;
      if (rst_cnt_q == SubRstCntW'(SubRstCycles - 1)) begin
        sub_rst_q <= 1'b0;
      end
    end
  end

  assign sub_rst_o = sub_rst_q;

  a_sub_rst_len : assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    $rose(sub_rst_o) |-> sub_rst_o [*SubRstCycles] ##1 !sub_rst_o
  ) else $error("fault_injector: sub-block reset length is wrong");

endmodule

`default_nettype wire

// ==== logic/fuse_arbiter.sv ====
// ----------------------------------------------------------
// Fuse array arbiter.
// Fixed priority of host, injector, then scanner onto the one
// array port, with read data steered back to its owner.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fuse_arbiter (
  input logic           clk,
  input logic           cptra_rst_b,
  fuse_mem_if.arbiter   host,
  fuse_mem_if.arbiter   inj,
  fuse_mem_if.arbiter   scan,
  fuse_mem_if.requester mem
);

  // Bit 0 marks the host, bit 1 the injector and bit 2 the scanner.
  logic [2:0] rd_owner_q;

  // ----------------------------------------------------------
  // Grant and request forwarding
  // ----------------------------------------------------------
  always_comb begin
    host.gnt = host.req & mem.gnt;
    inj.gnt  = inj.req & ~host.req & mem.gnt;
    scan.gnt = scan.req & ~host.req & ~inj.req & mem.gnt;
  end

  always_comb begin
    mem.req = host.req | inj.req | scan.req;
    if (host.req) begin
      mem.we    = host.we;
      mem.addr  = host.addr;
      mem.wdata = host.wdata;
    end else if (inj.req) begin
      mem.we    = inj.we;
      mem.addr  = inj.addr;
      mem.wdata = inj.wdata;
    end else begin
      mem.we    = scan.we;
      mem.addr  = scan.addr;
      mem.wdata = scan.wdata;
    end
  end

  // Remember who owned the read so the data lands only there.
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rd_owner_q <= '0;
    end else begin
      rd_owner_q <= {scan.gnt & ~scan.we, inj.gnt & ~inj.we, host.gnt & ~host.we};
    end
  end

  assign host.rdata = rd_owner_q[0] ? mem.rdata : '0;
  assign inj.rdata  = rd_owner_q[1] ? mem.rdata : '0;
  assign scan.rdata = rd_owner_q[2] ? mem.rdata : '0;

  a_gnt_onehot : assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    $onehot0({host.gnt, inj.gnt, scan.gnt})
  ) else $error("fuse_arbiter: more than one grant");

endmodule

`default_nettype wire

// ==== logic/fuse_array.sv ====
// ----------------------------------------------------------
// Fuse word storage.
// 32 words behind a single port that either writes or reads
// per cycle. Read data appears one cycle after the grant.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fuse_array (
  input logic         clk,
  fuse_mem_if.arbiter mem
);
  import fuse_svc_pkg::*;

  fuse_word_t word_q [NumParts * PartStride];

  // The array never stalls, so every request is accepted at once.
  assign mem.gnt = mem.req;

  always_ff @(posedge clk) begin
    if (mem.gnt) begin
      if (mem.we) begin
        word_q[mem.addr] <= mem.wdata;
      end else begin
        mem.rdata <= word_q[mem.addr];
      end
    end
  end

  // Nothing above the last digest word is part of any partition.
  a_addr_in_range : assert property (
    @(posedge clk) mem.req |-> (int'(mem.addr) <= LastUsedAddr)
  ) else $error("fuse_array: access beyond last partition at %0d", mem.addr);

endmodule

`default_nettype wire

// ==== logic/fuse_mem_if.sv ====
// ----------------------------------------------------------
// Fuse array access port.
// One requester talks to the arbiter (or the arbiter to the
// array) with a held request, a grant and registered rdata.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface fuse_mem_if;
  import fuse_svc_pkg::*;

  logic       req;
  logic       we;
  fuse_addr_t addr;
  fuse_word_t wdata;
  logic       gnt;
  fuse_word_t rdata;

  // Requester holds req until gnt, then reads rdata one cycle later.
  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

`default_nettype wire

// ==== logic/fuse_svc_pkg.sv ====
// ----------------------------------------------------------
// Fuse service package.
// Word and address types, the partition layout of the fuse
// array, the service command codes and the sub-block reset
// length shared by the injector, scanner and arbiter.
// ----------------------------------------------------------
`default_nettype none

package fuse_svc_pkg;

  // ----------------------------------------------------------
  // Partition layout
  // ----------------------------------------------------------
  localparam int NumParts      = 4;
  localparam int PartStride    = 8;
  localparam int PartDataWords = 4;
  localparam int DigestOffset  = 4;

  // Highest address that any block is allowed to touch.
  localparam int LastUsedAddr  = (NumParts - 1) * PartStride + DigestOffset;

  // Sub-block reset length in clock cycles.
  localparam int SubRstCycles  = 10;
  localparam int SubRstCntW    = $clog2(SubRstCycles);

  typedef logic [15:0]                   fuse_word_t;
  typedef logic [4:0]                    fuse_addr_t;
  typedef logic [7:0]                    svc_cmd_t;
  typedef logic [NumParts-1:0]           part_vec_t;
  typedef logic [$clog2(NumParts)-1:0]   part_idx_t;
  typedef logic [$clog2(PartStride)-1:0] word_idx_t;

  // ----------------------------------------------------------
  // Service command codes
  // ----------------------------------------------------------
  localparam svc_cmd_t CmdCorrFault    = 8'h01;
  localparam svc_cmd_t CmdUncorrFault  = 8'h02;
  localparam svc_cmd_t CmdReleaseFault = 8'h03;
  localparam svc_cmd_t CmdSubReset     = 8'h10;

  // First word of a partition.
  function automatic fuse_addr_t part_base(part_idx_t idx);
    return fuse_addr_t'(int'(idx) * PartStride);
  endfunction

  // Digest word of a partition.
  function automatic fuse_addr_t digest_addr(part_idx_t idx);
    return part_base(idx) + fuse_addr_t'(DigestOffset);
  endfunction

endpackage

`default_nettype wire
